// File: design/branch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decoder (
    input  mips_decode_pkg::opcode_e      opcode,
    input  mips_decode_pkg::funct_e       funct,
    input  mips_decode_pkg::reg_addr_t    rt,
    output mips_decode_pkg::branch_type_e branch_type,
    output logic                          is_link_pc8
);
    import mips_decode_pkg::*;

    always_comb begin
        branch_type = BT_NONE;
        is_link_pc8 = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FUN_JR || funct == FUN_JALR) begin
                    branch_type = BT_JREG;
                    is_link_pc8 = (funct == FUN_JALR);
                end
            end
            OP_J:    branch_type = BT_J;
            OP_JAL: begin
                branch_type = BT_J;
                is_link_pc8 = 1'b1; // $ra <= pc+8
            end
            OP_BEQ:  branch_type = BT_BEQ;
            OP_BNE:  branch_type = BT_BNE;
            OP_BGTZ: branch_type = BT_BGTZ;
            OP_BLEZ: branch_type = BT_BLEZ;
            OP_REGIMM: begin
                case (rt)
                    RT_BGEZ:   branch_type = BT_BGEZ;
                    RT_BLTZ:   branch_type = BT_BLTZ;
                    RT_BGEZAL: begin
                        branch_type = BT_BGEZ;
                        is_link_pc8 = 1'b1;
                    end
                    RT_BLTZAL: begin
                        branch_type = BT_BLTZ;
                        is_link_pc8 = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ctrl_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  mips_decode_pkg::opcode_e   opcode,
    input  mips_decode_pkg::funct_e    funct,
    input  mips_decode_pkg::reg_addr_t rt,
    output mips_decode_pkg::alu_op_e   alu_op,
    output logic                       read_rs,
    output logic                       read_rt,
    output logic                       reg_write,
    output logic                       hilo_read,
    output logic                       hilo_write,
    output logic                       mem_en,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       may_flush,
    output logic                       syscall_inst,
    output logic                       break_inst,
    output logic                       undefined_inst
);
    import mips_decode_pkg::*;

    function automatic alu_op_e special_alu_op(input funct_e f);
        case (f)
            FUN_AND:   return ALU_AND;
            FUN_OR:    return ALU_OR;
            FUN_XOR:   return ALU_XOR;
            FUN_NOR:   return ALU_NOR;
            FUN_SLT:   return ALU_SLT;
            FUN_SLTU:  return ALU_SLTU;
            FUN_ADD:   return ALU_ADD;
            FUN_ADDU:  return ALU_ADDU;
            FUN_SUB:   return ALU_SUB;
            FUN_SUBU:  return ALU_SUBU;
            FUN_SLL:   return ALU_SLL;
            FUN_SLLV:  return ALU_SLLV;
            FUN_SRL:   return ALU_SRL;
            FUN_SRLV:  return ALU_SRLV;
            FUN_SRA:   return ALU_SRA;
            FUN_SRAV:  return ALU_SRAV;
            FUN_MULT:  return ALU_MULT;
            FUN_MULTU: return ALU_MULTU;
            FUN_DIV:   return ALU_DIV;
            FUN_DIVU:  return ALU_DIVU;
            FUN_MFHI:  return ALU_MFHI;
            FUN_MFLO:  return ALU_MFLO;
            FUN_MTHI:  return ALU_MTHI;
            FUN_MTLO:  return ALU_MTLO;
            default:   return ALU_NOP; // jumps, traps to kernel, sync
        endcase
    endfunction

    // immediate forms reuse the register-register ops
    function automatic alu_op_e imm_alu_op(input opcode_e op);
        case (op)
            OP_ADDI:  return ALU_ADD;
            OP_ADDIU: return ALU_ADDU;
            OP_SLTI:  return ALU_SLT;
            OP_SLTIU: return ALU_SLTU;
            OP_ANDI:  return ALU_AND;
            OP_ORI:   return ALU_OR;
            OP_XORI:  return ALU_XOR;
            OP_LUI:   return ALU_LUI;
            default:  return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        alu_op         = ALU_NOP;
        read_rs        = 1'b0;
        read_rt        = 1'b0;
        reg_write      = 1'b0;
        hilo_read      = 1'b0;
        hilo_write     = 1'b0;
        mem_en         = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        may_flush      = 1'b0;
        syscall_inst   = 1'b0;
        break_inst     = 1'b0;
        undefined_inst = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUN_AND, FUN_OR, FUN_XOR, FUN_NOR, FUN_SLT, FUN_SLTU,
                    FUN_ADD, FUN_ADDU, FUN_SUB, FUN_SUBU,
                    FUN_SLLV, FUN_SRLV, FUN_SRAV: begin
                        alu_op    = special_alu_op(funct);
                        read_rs   = 1'b1;
                        read_rt   = 1'b1;
                        reg_write = 1'b1;
                    end
                    FUN_SLL, FUN_SRL, FUN_SRA: begin // shift by shamt
                        alu_op    = special_alu_op(funct);
                        read_rt   = 1'b1;
                        reg_write = 1'b1;
                    end
                    FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU: begin
                        alu_op     = special_alu_op(funct);
                        read_rs    = 1'b1;
                        read_rt    = 1'b1;
                        hilo_write = 1'b1;
                    end
                    FUN_MFHI, FUN_MFLO: begin
                        alu_op    = special_alu_op(funct);
                        hilo_read = 1'b1;
                        reg_write = 1'b1;
                    end
                    FUN_MTHI, FUN_MTLO: begin
                        alu_op     = special_alu_op(funct);
                        read_rs    = 1'b1;
                        hilo_write = 1'b1;
                    end
                    FUN_JR: begin
                        read_rs   = 1'b1;
                        may_flush = 1'b1;
                    end
                    FUN_JALR: begin
                        read_rs   = 1'b1;
                        reg_write = 1'b1; // rd <= pc+8
                        may_flush = 1'b1;
                    end
                    FUN_SYSCALL: begin
                        syscall_inst = 1'b1;
                        may_flush    = 1'b1;
                    end
                    FUN_BREAK: begin
                        break_inst = 1'b1;
                        may_flush  = 1'b1;
                    end
                    FUN_SYNC:  may_flush = 1'b1;
                    default:   undefined_inst = 1'b1;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                mem_en    = 1'b1;
                mem_read  = 1'b1;
                read_rs   = 1'b1;
                reg_write = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                mem_en    = 1'b1;
                mem_write = 1'b1;
                read_rs   = 1'b1;
                read_rt   = 1'b1; // store data
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                alu_op    = imm_alu_op(opcode);
                read_rs   = 1'b1;
                reg_write = 1'b1;
            end
            OP_J:   may_flush = 1'b1;
            OP_JAL: begin
                reg_write = 1'b1;
                may_flush = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                read_rs   = 1'b1;
                read_rt   = 1'b1;
                may_flush = 1'b1;
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ, RT_BGEZ: begin
                        read_rs   = 1'b1;
                        may_flush = 1'b1;
                    end
                    RT_BLTZAL, RT_BGEZAL: begin
                        read_rs   = 1'b1;
                        read_rt   = 1'b1;
                        reg_write = 1'b1;
                        may_flush = 1'b1;
                    end
                    default: undefined_inst = 1'b1;
                endcase
            end
            default: undefined_inst = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  mips_decode_pkg::word_t        instr,
    output logic                          out_valid,
    output mips_decode_pkg::reg_addr_t    rs,
    output mips_decode_pkg::reg_addr_t    rt,
    output mips_decode_pkg::reg_addr_t    reg_waddr,
    output mips_decode_pkg::alu_op_e      alu_op,
    output logic                          read_rs,
    output logic                          read_rt,
    output logic                          reg_write,
    output logic                          hilo_read,
    output logic                          hilo_write,
    output logic                          mem_en,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          may_flush,
    output logic                          syscall_inst,
    output logic                          break_inst,
    output logic                          undefined_inst,
    output mips_decode_pkg::branch_type_e branch_type,
    output logic                          is_link_pc8,
    output mips_decode_pkg::word_t        imm_value,
    output mips_decode_pkg::word_t        shamt_value
);
    import mips_decode_pkg::*;

    opcode_e               in_opcode;
    funct_e                in_funct;
    reg_addr_t             in_rs;
    reg_addr_t             in_rt;
    reg_addr_t             in_rd;
    reg_addr_t             in_shamt;
    logic [IMM_W-1:0]      in_imm;
    alu_op_e               dec_alu_op;
    logic [11:0]           dec_flags;
    branch_type_e          dec_branch_type;
    logic                  dec_link;
    reg_addr_t             dec_waddr;
    word_t                 dec_imm;
    word_t                 dec_shamt;

    // field split
    assign in_opcode = opcode_e'(instr[31:26]);
    assign in_rs     = instr[25:21];
    assign in_rt     = instr[20:16];
    assign in_rd     = instr[15:11];
    assign in_shamt  = instr[10:6];
    assign in_funct  = funct_e'(instr[5:0]);
    assign in_imm    = instr[IMM_W-1:0];

    ctrl_decoder u_ctrl_decoder (
        .opcode         (in_opcode),
        .funct          (in_funct),
        .rt             (in_rt),
        .alu_op         (dec_alu_op),
        .read_rs        (dec_flags[11]),
        .read_rt        (dec_flags[10]),
        .reg_write      (dec_flags[9]),
        .hilo_read      (dec_flags[8]),
        .hilo_write     (dec_flags[7]),
        .mem_en         (dec_flags[6]),
        .mem_read       (dec_flags[5]),
        .mem_write      (dec_flags[4]),
        .may_flush      (dec_flags[3]),
        .syscall_inst   (dec_flags[2]),
        .break_inst     (dec_flags[1]),
        .undefined_inst (dec_flags[0])
    );

    branch_decoder u_branch_decoder (
        .opcode      (in_opcode),
        .funct       (in_funct),
        .rt          (in_rt),
        .branch_type (dec_branch_type),
        .is_link_pc8 (dec_link)
    );

    operand_decoder u_operand_decoder (
        .opcode      (in_opcode),
        .rt          (in_rt),
        .rd          (in_rd),
        .shamt       (in_shamt),
        .imm         (in_imm),
        .reg_waddr   (dec_waddr),
        .imm_value   (dec_imm),
        .shamt_value (dec_shamt)
    );

    // control side, cleared whenever no instruction was sampled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            alu_op      <= ALU_NOP;
            branch_type <= BT_NONE;
            is_link_pc8 <= 1'b0;
            {read_rs, read_rt, reg_write, hilo_read, hilo_write, mem_en, mem_read,
             mem_write, may_flush, syscall_inst, break_inst, undefined_inst} <= '0;
        end else begin
            out_valid   <= in_valid;
            alu_op      <= in_valid ? dec_alu_op : ALU_NOP;
            branch_type <= in_valid ? dec_branch_type : BT_NONE;
            is_link_pc8 <= in_valid & dec_link;
            {read_rs, read_rt, reg_write, hilo_read, hilo_write, mem_en, mem_read,
             mem_write, may_flush, syscall_inst, break_inst, undefined_inst}
                <= in_valid ? dec_flags : '0;
        end
    end

    // payload fields, only loaded with a valid instruction
    always_ff @(posedge clk) begin
        if (in_valid) begin
            rs          <= in_rs;
            rt          <= in_rt;
            reg_waddr   <= dec_waddr;
            imm_value   <= dec_imm;
            shamt_value <= dec_shamt;
        end
    end

endmodule

`default_nettype wire

// File: design/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int ALU_OP_W   = 5;
    localparam int BRANCH_W   = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t LINK_REG = 5'd31; // $ra

    // primary opcode, instr[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        FUN_SLL     = 6'b000000,
        FUN_SRL     = 6'b000010,
        FUN_SRA     = 6'b000011,
        FUN_SLLV    = 6'b000100,
        FUN_SRLV    = 6'b000110,
        FUN_SRAV    = 6'b000111,
        FUN_JR      = 6'b001000,
        FUN_JALR    = 6'b001001,
        FUN_SYSCALL = 6'b001100,
        FUN_BREAK   = 6'b001101,
        FUN_SYNC    = 6'b001111,
        FUN_MFHI    = 6'b010000,
        FUN_MTHI    = 6'b010001,
        FUN_MFLO    = 6'b010010,
        FUN_MTLO    = 6'b010011,
        FUN_MULT    = 6'b011000,
        FUN_MULTU   = 6'b011001,
        FUN_DIV     = 6'b011010,
        FUN_DIVU    = 6'b011011,
        FUN_ADD     = 6'b100000,
        FUN_ADDU    = 6'b100001,
        FUN_SUB     = 6'b100010,
        FUN_SUBU    = 6'b100011,
        FUN_AND     = 6'b100100,
        FUN_OR      = 6'b100101,
        FUN_XOR     = 6'b100110,
        FUN_NOR     = 6'b100111,
        FUN_SLT     = 6'b101010,
        FUN_SLTU    = 6'b101011
    } funct_e;

    // REGIMM branches live in the rt field
    typedef enum logic [REG_ADDR_W-1:0] {
        RT_BLTZ   = 5'b00000,
        RT_BGEZ   = 5'b00001,
        RT_BLTZAL = 5'b10000,
        RT_BGEZAL = 5'b10001
    } regimm_e;

    // encoding order is shared with the test vectors
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NOP = 5'd0,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLL, ALU_SLLV, ALU_SRL, ALU_SRLV, ALU_SRA, ALU_SRAV,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
        ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [BRANCH_W-1:0] {
        BT_NONE = 4'd0,
        BT_J,
        BT_JREG,   // target from rs
        BT_BEQ,
        BT_BNE,
        BT_BGTZ,
        BT_BLEZ,
        BT_BGEZ,
        BT_BLTZ
    } branch_type_e;

endpackage

`default_nettype wire

// File: design/operand_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module operand_decoder (
    input  mips_decode_pkg::opcode_e          opcode,
    input  mips_decode_pkg::reg_addr_t        rt,
    input  mips_decode_pkg::reg_addr_t        rd,
    input  mips_decode_pkg::reg_addr_t        shamt,
    input  logic [mips_decode_pkg::IMM_W-1:0] imm,
    output mips_decode_pkg::reg_addr_t        reg_waddr,
    output mips_decode_pkg::word_t            imm_value,
    output mips_decode_pkg::word_t            shamt_value
);
    import mips_decode_pkg::*;

    logic zero_ext;

    // andi, ori, xori, lui all have opcode[3:2] == 2'b11
    assign zero_ext    = (opcode[3:2] == 2'b11);
    assign imm_value   = zero_ext ? {{(WORD_W-IMM_W){1'b0}}, imm}
                                  : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign shamt_value = {{(WORD_W-REG_ADDR_W){1'b0}}, shamt};

    always_comb begin
        reg_waddr = rd;
        case (opcode)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_waddr = rt; // i-type destination
            end
            OP_JAL: reg_waddr = LINK_REG;
            OP_REGIMM: begin
                // linking branches only, plain ones keep rd
                if (rt == RT_BGEZAL || rt == RT_BLTZAL) begin
                    reg_waddr = LINK_REG;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --timescale 1ns/1ps -f src.f \
    --top-module decode_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_output=$(./obj_dir/Vdecode_stage_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
    import mips_decode_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int BURST_LEN    = 3; // instructions issued back to back
    localparam int FIELD_COUNT  = 7;

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    word_t        instr;
    logic         out_valid;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    reg_waddr;
    alu_op_e      alu_op;
    logic         read_rs;
    logic         read_rt;
    logic         reg_write;
    logic         hilo_read;
    logic         hilo_write;
    logic         mem_en;
    logic         mem_read;
    logic         mem_write;
    logic         may_flush;
    logic         syscall_inst;
    logic         break_inst;
    logic         undefined_inst;
    branch_type_e branch_type;
    logic         is_link_pc8;
    word_t        imm_value;
    word_t        shamt_value;

    // one entry per line of the vector file
    word_t        vec_instr[$];
    logic [4:0]   vec_alu[$];
    logic [11:0]  vec_flags[$];
    logic [3:0]   vec_branch[$];
    logic         vec_link[$];
    reg_addr_t    vec_waddr[$];
    word_t        vec_imm[$];

    int num_tests;
    int error_count;
    int pass_count;
    int fail_count;

    decode_stage u_decode_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .instr          (instr),
        .out_valid      (out_valid),
        .rs             (rs),
        .rt             (rt),
        .reg_waddr      (reg_waddr),
        .alu_op         (alu_op),
        .read_rs        (read_rs),
        .read_rt        (read_rt),
        .reg_write      (reg_write),
        .hilo_read      (hilo_read),
        .hilo_write     (hilo_write),
        .mem_en         (mem_en),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .may_flush      (may_flush),
        .syscall_inst   (syscall_inst),
        .break_inst     (break_inst),
        .undefined_inst (undefined_inst),
        .branch_type    (branch_type),
        .is_link_pc8    (is_link_pc8),
        .imm_value      (imm_value),
        .shamt_value    (shamt_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // same bit order as the flag column of the vector file
    function automatic logic [11:0] packed_flags();
        return {read_rs, read_rt, reg_write, hilo_read, hilo_write, mem_en, mem_read,
                mem_write, may_flush, syscall_inst, break_inst, undefined_inst};
    endfunction

    function automatic string flag_name(input int bit_pos);
        case (bit_pos)
            11:      return "read_rs";
            10:      return "read_rt";
            9:       return "reg_write";
            8:       return "hilo_read";
            7:       return "hilo_write";
            6:       return "mem_en";
            5:       return "mem_read";
            4:       return "mem_write";
            3:       return "may_flush";
            2:       return "syscall_inst";
            1:       return "break_inst";
            default: return "undefined_inst";
        endcase
    endfunction

    task automatic compare_field(input string where, input string name,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: %s expected %h got %h", where, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_instr, f_alu, f_flags, f_branch, f_link, f_waddr, f_imm;
        ok = 1'b0;
        fd = $fopen("sim/decode_tests.hex", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/decode_tests.hex");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h", f_instr, f_alu, f_flags,
                                 f_branch, f_link, f_waddr, f_imm);
                    if (rc == FIELD_COUNT) begin
                        vec_instr.push_back(f_instr);
                        vec_alu.push_back(f_alu[4:0]);
                        vec_flags.push_back(f_flags[11:0]);
                        vec_branch.push_back(f_branch[3:0]);
                        vec_link.push_back(f_link[0]);
                        vec_waddr.push_back(f_waddr[4:0]);
                        vec_imm.push_back(f_imm);
                    end else if (line.len() > 1 && line.substr(0, 1) != "//") begin
                        $display("could not read vector line %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            num_tests = vec_instr.size();
            ok = (num_tests > 0);
        end
    endtask

    // no instruction on the outputs, control side all cleared
    task automatic expect_quiet(input string where);
        logic [11:0] flags_now;
        int          b;
        flags_now = packed_flags();
        compare_field(where, "out_valid", 32'd0, 32'(out_valid));
        compare_field(where, "alu_op", 32'd0, 32'(alu_op));
        compare_field(where, "branch_type", 32'd0, 32'(branch_type));
        compare_field(where, "is_link_pc8", 32'd0, 32'(is_link_pc8));
        for (b = 11; b >= 0; b--) begin
            compare_field(where, flag_name(b), 32'd0, 32'(flags_now[b[3:0]]));
        end
    endtask

    // idle cycle, payload fields keep the last instruction
    task automatic confirm_idle(input int last);
        string where;
        word_t last_instr;
        where = $sformatf("idle after test %0d", last);
        last_instr = vec_instr[last];
        expect_quiet(where);
        compare_field(where, "rs", 32'(last_instr[25:21]), 32'(rs));
        compare_field(where, "rt", 32'(last_instr[20:16]), 32'(rt));
        compare_field(where, "reg_waddr", 32'(vec_waddr[last]), 32'(reg_waddr));
        compare_field(where, "imm_value", vec_imm[last], imm_value);
        compare_field(where, "shamt_value", 32'(last_instr[10:6]), shamt_value);
    endtask

    task automatic verify_decode(input int idx);
        string       where;
        int          errors_before;
        logic [11:0] flags_now;
        logic [11:0] exp_flags;
        word_t       exp_instr;
        int          b;
        where = $sformatf("test %0d", idx);
        errors_before = error_count;
        flags_now = packed_flags();
        exp_flags = vec_flags[idx];
        exp_instr = vec_instr[idx];
        compare_field(where, "out_valid", 32'd1, 32'(out_valid));
        compare_field(where, "alu_op", 32'(vec_alu[idx]), 32'(alu_op));
        for (b = 11; b >= 0; b--) begin
            compare_field(where, flag_name(b), 32'(exp_flags[b[3:0]]),
                          32'(flags_now[b[3:0]]));
        end
        compare_field(where, "branch_type", 32'(vec_branch[idx]), 32'(branch_type));
        compare_field(where, "is_link_pc8", 32'(vec_link[idx]), 32'(is_link_pc8));
        compare_field(where, "reg_waddr", 32'(vec_waddr[idx]), 32'(reg_waddr));
        compare_field(where, "imm_value", vec_imm[idx], imm_value);
        compare_field(where, "rs", 32'(exp_instr[25:21]), 32'(rs));
        compare_field(where, "rt", 32'(exp_instr[20:16]), 32'(rt));
        compare_field(where, "shamt_value", 32'(exp_instr[10:6]), shamt_value);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d instr %h ok", idx, exp_instr);
        end else begin
            fail_count++;
            $display("test %0d instr %h failed", idx, exp_instr);
        end
    endtask

    // bursts of back to back issue, each followed by one idle cycle
    task automatic run_tests();
        int next_idx;
        int pending;
        int burst_pos;
        next_idx = 0;
        pending = -1;
        burst_pos = 0;
        while (next_idx < num_tests || pending >= 0) begin
            @(negedge clk);
            if (pending >= 0) begin
                verify_decode(pending);
            end else if (next_idx > 0) begin
                confirm_idle(next_idx - 1);
            end
            if (next_idx < num_tests && burst_pos < BURST_LEN) begin
                instr = vec_instr[next_idx];
                in_valid = 1'b1;
                pending = next_idx;
                next_idx++;
                burst_pos++;
            end else begin
                instr = '1; // junk word, must not reach the fields
                in_valid = 1'b0;
                pending = -1;
                burst_pos = 0;
            end
        end
    endtask

    initial begin
        bit ok;
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        num_tests = 0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        load_vectors(ok);
        if (!ok) begin
            $display("no test vectors could be loaded");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            repeat (RESET_CYCLES / 2) @(negedge clk);
            expect_quiet("during reset");
            repeat (RESET_CYCLES - RESET_CYCLES / 2) @(negedge clk);
            arst_n = 1'b1;
            @(negedge clk);
            expect_quiet("after reset");
            run_tests();
            @(negedge clk);
            confirm_idle(num_tests - 1);
            $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                     num_tests, pass_count, fail_count, error_count);
            if (error_count == 0 && fail_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

    initial begin
        wait (arst_n === 1'b1);
        #((num_tests + 20) * CLK_PERIOD);
        $display("simulation timed out, tests did not complete within %0d clock periods",
                 num_tests + 20);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/decode_tests.hex
// columns are instr alu_op flags branch_type is_link_pc8 reg_waddr imm_value in hex
// flag bits 11..0 rs rt wr hi_rd hi_wr mem_en mem_rd mem_wr flush syscall break undef
00221824 01 e00 0 0 03 00001824
012a402a 05 e00 0 0 08 0000402a
02538823 0a e00 0 0 11 ffff8823
000521c0 0b 600 0 0 04 000021c0
01073007 10 e00 0 0 06 00003007
012a0018 11 c80 0 0 00 00000018
00006010 15 300 0 0 0c 00006010
01a00013 18 880 0 0 00 00000013
20c5fffc 07 a00 0 0 05 fffffffc
35078001 02 a00 0 0 07 00008001
3c09abcd 19 a00 0 0 09 0000abcd
2d6a8000 06 a00 0 0 0a ffff8000
3841f0f0 03 a00 0 0 01 0000f0f0
8fa8fff8 00 a60 0 0 08 fffffff8
90890003 00 a60 0 0 09 00000003
a0c50001 00 c50 0 0 00 00000001
afbf7ffc 00 c50 0 0 0f 00007ffc
08100040 00 008 1 0 00 00000040
0c012345 00 208 1 1 1f 00002345
03e00008 00 808 2 0 00 00000008
0080f809 00 a08 2 1 1f fffff809
1022ffff 00 c08 3 0 1f ffffffff
18600010 00 c08 6 0 00 00000010
04b10020 00 e08 7 1 1f 00000020
04c0fffe 00 808 8 0 1f fffffffe
0000000c 00 00c 0 0 00 0000000c
0000000d 00 00a 0 0 00 0000000d
0000000f 00 008 0 0 00 0000000f
40026000 00 001 0 0 0c 00006000
0022180a 00 001 0 0 03 0000180a
04880005 00 001 0 0 00 00000005

// File: src.f
design/mips_decode_pkg.sv
design/ctrl_decoder.sv
design/branch_decoder.sv
design/operand_decoder.sv
design/decode_stage.sv
sim/decode_stage_tb.sv
